// File: src/conv_index_settings.svh
`ifndef CONV_INDEX_SETTINGS_SVH
`define CONV_INDEX_SETTINGS_SVH

// input image geometry
`define CI_IMG_W 6
`define CI_IMG_H 5
`define CI_CHANNELS 2

// kernel side and tap count
`define CI_KERNEL 3
`define CI_TAPS 9

// ram_en cycles per load
`define CI_LOAD_CYCLES 10

// ram address widths
`define CI_IMG_AW 8
`define CI_FLT_AW 5

`endif

// File: src/index_pkg.sv
package index_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DECIDE,
        WAIT_START,
        WHOLE_DONE
    } index_state_e;

    // one window step per DECIDE cycle
    typedef enum logic [2:0] {
        STEP_NONE,
        STEP_TAP_COL,
        STEP_TAP_ROW,
        STEP_OFMAP_ROW,
        STEP_OFMAP_COL,
        STEP_CHANNEL,
        STEP_CLEAR
    } step_op_e;

    typedef struct packed {
        logic tap_col_full;
        logic tap_full;
        logic load_full;
    } win_flags_t;

endpackage

// File: src/addr_pkg.sv
`include "conv_index_settings.svh"

package addr_pkg;

    // output map boundaries
    typedef struct packed {
        logic last_row;
        logic last_col;
        logic last_channel;
    } edge_flags_t;

    typedef struct packed {
        logic [`CI_FLT_AW-1:0] filter_addr;
        logic [`CI_IMG_AW-1:0] image_addr;
    } ram_addr_t;

endpackage

// File: src/index_fsm.sv
module index_fsm (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  index_start,
    input  index_pkg::win_flags_t win_flags,
    input  addr_pkg::edge_flags_t edge_flags,
    output index_pkg::step_op_e   step_op,
    output logic                  load_en,
    output logic                  ram_en,
    output logic                  load_done,
    output logic                  whole_done
);
    import index_pkg::*;

    index_state_e state;
    index_state_e next_state;
    logic         last_window;

    // final tap of final window of final channel
    assign last_window = win_flags.tap_col_full & win_flags.tap_full &
                         edge_flags.last_row & edge_flags.last_col &
                         edge_flags.last_channel;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (index_start) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                if (win_flags.load_full) begin
                    next_state = DECIDE;
                end
            end
            DECIDE: begin
                next_state = last_window ? WHOLE_DONE : WAIT_START;
            end
            WAIT_START: begin
                if (index_start) begin
                    next_state = LOAD;
                end
            end
            WHOLE_DONE: begin
                next_state = WHOLE_DONE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // step choice, innermost loop first
    always_comb begin
        step_op = STEP_NONE;
        case (state)
            IDLE: begin
                step_op = STEP_CLEAR;
            end
            DECIDE: begin
                if (!win_flags.tap_col_full) begin
                    step_op = STEP_TAP_COL;
                end else if (!win_flags.tap_full) begin
                    step_op = STEP_TAP_ROW;
                end else if (!edge_flags.last_row) begin
                    step_op = STEP_OFMAP_ROW;
                end else if (!edge_flags.last_col) begin
                    step_op = STEP_OFMAP_COL;
                end else if (!edge_flags.last_channel) begin
                    step_op = STEP_CHANNEL;
                end
            end
            default: begin
                step_op = STEP_NONE;
            end
        endcase
    end

    // decoded straight from the state register
    assign load_en    = (state == LOAD);
    assign ram_en     = (state == LOAD);
    assign load_done  = (state == DECIDE);
    assign whole_done = (state == WHOLE_DONE);

endmodule

// File: src/window_counters.sv
`include "conv_index_settings.svh"

module window_counters (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  load_en,
    input  index_pkg::step_op_e   step_op,
    output index_pkg::win_flags_t win_flags
);
    import index_pkg::*;

    localparam int LOAD_W = $clog2(`CI_LOAD_CYCLES);
    localparam int COL_W  = $clog2(`CI_KERNEL);
    localparam int TAP_W  = $clog2(`CI_TAPS);

    logic [LOAD_W-1:0] load_cnt;
    logic [COL_W-1:0]  tap_col;
    logic [TAP_W-1:0]  tap;

    always_ff @(posedge CLK) begin
        if (RST) begin
            load_cnt <= '0;
        end else if (load_en && !win_flags.load_full) begin
            load_cnt <= load_cnt + 1'b1;
        end else begin
            load_cnt <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            tap_col <= '0;
            tap     <= '0;
        end else begin
            case (step_op)
                STEP_TAP_COL: begin
                    tap_col <= tap_col + 1'b1;
                    tap     <= tap + 1'b1;
                end
                STEP_TAP_ROW: begin
                    tap_col <= '0;
                    tap     <= tap + 1'b1;
                end
                STEP_OFMAP_ROW, STEP_OFMAP_COL, STEP_CHANNEL, STEP_CLEAR: begin
                    tap_col <= '0;
                    tap     <= '0;
                end
                default: ;
            endcase
        end
    end

    assign win_flags.tap_col_full = (tap_col == COL_W'(`CI_KERNEL - 1));
    assign win_flags.tap_full     = (tap == TAP_W'(`CI_TAPS - 1));
    assign win_flags.load_full    = (load_cnt == LOAD_W'(`CI_LOAD_CYCLES - 1));

endmodule

// File: src/filter_addr_gen.sv
`include "conv_index_settings.svh"

module filter_addr_gen (
    input  logic                  CLK,
    input  logic                  RST,
    input  index_pkg::step_op_e   step_op,
    output logic [`CI_FLT_AW-1:0] filter_addr
);
    import index_pkg::*;

    localparam int OFS_W = $clog2(`CI_TAPS);

    logic [`CI_FLT_AW-1:0] base;
    logic [OFS_W-1:0]      offset;

    always_ff @(posedge CLK) begin
        if (RST) begin
            base   <= '0;
            offset <= '0;
        end else begin
            case (step_op)
                STEP_TAP_COL, STEP_TAP_ROW: begin
                    offset <= offset + 1'b1;
                end
                STEP_OFMAP_ROW, STEP_OFMAP_COL: begin
                    offset <= '0;
                end
                // next channel's kernel follows directly
                STEP_CHANNEL: begin
                    base   <= base + `CI_FLT_AW'(`CI_TAPS);
                    offset <= '0;
                end
                STEP_CLEAR: begin
                    base   <= '0;
                    offset <= '0;
                end
                default: ;
            endcase
        end
    end

    assign filter_addr = base + `CI_FLT_AW'(offset);

endmodule

// File: src/image_addr_gen.sv
`include "conv_index_settings.svh"

module image_addr_gen (
    input  logic                  CLK,
    input  logic                  RST,
    input  index_pkg::step_op_e   step_op,
    output logic [`CI_IMG_AW-1:0] image_addr,
    output addr_pkg::edge_flags_t edge_flags
);
    import index_pkg::*;

    // output map extent per direction
    localparam int OUT_H = `CI_IMG_H - `CI_KERNEL + 1;
    localparam int OUT_W = `CI_IMG_W - `CI_KERNEL + 1;
    localparam int ROW_W = $clog2(OUT_H);
    localparam int COL_W = $clog2(OUT_W);
    localparam int CH_W  = $clog2(`CI_CHANNELS);
    localparam int TK_W  = $clog2(`CI_KERNEL);

    logic [ROW_W-1:0] out_row;
    logic [COL_W-1:0] out_col;
    logic [CH_W-1:0]  channel;
    logic [TK_W-1:0]  tap_row;
    logic [TK_W-1:0]  tap_col;

    always_ff @(posedge CLK) begin
        if (RST) begin
            out_row <= '0;
            out_col <= '0;
            channel <= '0;
            tap_row <= '0;
            tap_col <= '0;
        end else begin
            case (step_op)
                STEP_TAP_COL: begin
                    tap_col <= tap_col + 1'b1;
                end
                STEP_TAP_ROW: begin
                    tap_col <= '0;
                    tap_row <= tap_row + 1'b1;
                end
                STEP_OFMAP_ROW: begin
                    tap_col <= '0;
                    tap_row <= '0;
                    out_row <= out_row + 1'b1;
                end
                STEP_OFMAP_COL: begin
                    tap_col <= '0;
                    tap_row <= '0;
                    out_row <= '0;
                    out_col <= out_col + 1'b1;
                end
                STEP_CHANNEL: begin
                    tap_col <= '0;
                    tap_row <= '0;
                    out_row <= '0;
                    out_col <= '0;
                    channel <= channel + 1'b1;
                end
                STEP_CLEAR: begin
                    tap_col <= '0;
                    tap_row <= '0;
                    out_row <= '0;
                    out_col <= '0;
                    channel <= '0;
                end
                default: ;
            endcase
        end
    end

    // channel plane, then pixel row, then pixel column
    assign image_addr = `CI_IMG_AW'(channel) * `CI_IMG_AW'(`CI_IMG_H * `CI_IMG_W)
                      + (`CI_IMG_AW'(out_row) + `CI_IMG_AW'(tap_row)) * `CI_IMG_AW'(`CI_IMG_W)
                      + `CI_IMG_AW'(out_col) + `CI_IMG_AW'(tap_col);

    assign edge_flags.last_row     = (out_row == ROW_W'(OUT_H - 1));
    assign edge_flags.last_col     = (out_col == COL_W'(OUT_W - 1));
    assign edge_flags.last_channel = (channel == CH_W'(`CI_CHANNELS - 1));

endmodule

// File: src/conv_indexer.sv
`include "conv_index_settings.svh"

module conv_indexer (
    input  logic                CLK,
    input  logic                RST,
    input  logic                index_start,
    output addr_pkg::ram_addr_t ram_addr,
    output logic                ram_en,
    output logic                load_done,
    output logic                whole_done
);
    import index_pkg::*;
    import addr_pkg::*;

    step_op_e              step_op;
    win_flags_t            win_flags;
    edge_flags_t           edge_flags;
    logic                  load_en;
    logic [`CI_FLT_AW-1:0] filter_addr;
    logic [`CI_IMG_AW-1:0] image_addr;

    index_fsm u_fsm (
        .CLK         (CLK),
        .RST         (RST),
        .index_start (index_start),
        .win_flags   (win_flags),
        .edge_flags  (edge_flags),
        .step_op     (step_op),
        .load_en     (load_en),
        .ram_en      (ram_en),
        .load_done   (load_done),
        .whole_done  (whole_done)
    );

    window_counters u_counters (
        .CLK       (CLK),
        .RST       (RST),
        .load_en   (load_en),
        .step_op   (step_op),
        .win_flags (win_flags)
    );

    filter_addr_gen u_filter_addr (
        .CLK         (CLK),
        .RST         (RST),
        .step_op     (step_op),
        .filter_addr (filter_addr)
    );

    image_addr_gen u_image_addr (
        .CLK        (CLK),
        .RST        (RST),
        .step_op    (step_op),
        .image_addr (image_addr),
        .edge_flags (edge_flags)
    );

    assign ram_addr = '{filter_addr: filter_addr, image_addr: image_addr};

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic CLK,
    output logic RST
);
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // reset spans four rising edges, released on a falling one
    initial begin
        RST = 1'b1;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
    end
endmodule

// File: testbench/tb_conv_indexer.sv
`include "conv_index_settings.svh"

module tb_conv_indexer;
    import addr_pkg::*;

    localparam int OUT_ROWS       = `CI_IMG_H - 2;
    localparam int OUT_COLS       = `CI_IMG_W - 2;
    localparam int WINDOWS        = OUT_ROWS * OUT_COLS;
    localparam int CH_LOADS       = WINDOWS * `CI_TAPS;
    localparam int TOTAL_LOADS    = CH_LOADS * `CI_CHANNELS;
    localparam int TIMEOUT_CYCLES = TOTAL_LOADS * (`CI_LOAD_CYCLES + 6) + 200;

    logic        CLK;
    logic        RST;
    logic        index_start;
    ram_addr_t   ram_addr;
    logic        ram_en;
    logic        load_done;
    logic        whole_done;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          err_count;
    int          load_idx;
    int          run_len;
    int          tests_passed;
    int          tests_failed;
    logic        check_en;
    logic        prev_load_done;
    logic        whole_seen;

    tb_clock_gen clock_gen (.CLK(CLK), .RST(RST));

    conv_indexer UUT (
        .CLK         (CLK),
        .RST         (RST),
        .index_start (index_start),
        .ram_addr    (ram_addr),
        .ram_en      (ram_en),
        .load_done   (load_done),
        .whole_done  (whole_done)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // window index runs output row first, then output column
    function automatic ram_addr_t expected_addr(input int window, input int tap,
                                                input int channel);
        int        out_row;
        int        out_col;
        ram_addr_t r;
        out_row = window % OUT_ROWS;
        out_col = window / OUT_ROWS;
        r.filter_addr = `CI_FLT_AW'(channel * `CI_TAPS + tap);
        r.image_addr  = `CI_IMG_AW'(channel * `CI_IMG_H * `CI_IMG_W
                        + (out_row + tap / `CI_KERNEL) * `CI_IMG_W
                        + out_col + tap % `CI_KERNEL);
        return r;
    endfunction

    task automatic pulse_start();
        index_start = 1'b1;
        @(negedge CLK);
        index_start = 1'b0;
    endtask

    task automatic run_load(input bit mid_pulse);
        logic [1:0] gap;
        int         waited;
        lfsr_state = lfsr_next(lfsr_state);
        gap[0] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap[1] = lfsr_state[0];
        repeat (gap) @(negedge CLK);
        pulse_start();
        // first load cycle follows the sampled start
        if (ram_en !== 1'b1) begin
            $display("ERR ram_en after start: got %h expected %h", ram_en, 1'b1);
            err_count++;
        end
        waited = 1;
        if (mid_pulse) begin
            repeat (3) @(negedge CLK);
            pulse_start();
            waited += 4;
        end
        while (load_done !== 1'b1) begin
            @(negedge CLK);
            waited++;
        end
        if (waited != `CI_LOAD_CYCLES + 1) begin
            $display("ERR load_done cycle after start: got %h expected %h",
                     waited, `CI_LOAD_CYCLES + 1);
            err_count++;
        end
        @(negedge CLK);
    endtask

    // rising edge keeps the tally clear of the negedge compare
    task automatic report_test(input string name, input int errs_before);
        @(posedge CLK);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
        @(negedge CLK);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    always @(negedge CLK) begin : compare_outputs
        ram_addr_t exp_addr;
        if (!RST && check_en) begin
            if (ram_en) begin
                if (load_idx >= TOTAL_LOADS) begin
                    $display("ram_en went high after the last load, cycle %0d", cycle_count);
                    err_count++;
                end else begin
                    exp_addr = expected_addr((load_idx / `CI_TAPS) % WINDOWS,
                                             load_idx % `CI_TAPS, load_idx / CH_LOADS);
                    if (ram_addr.filter_addr !== exp_addr.filter_addr) begin
                        $display("ERR load %0d filter_addr: got %h expected %h",
                                 load_idx, ram_addr.filter_addr, exp_addr.filter_addr);
                        err_count++;
                    end
                    if (ram_addr.image_addr !== exp_addr.image_addr) begin
                        $display("ERR load %0d image_addr: got %h expected %h",
                                 load_idx, ram_addr.image_addr, exp_addr.image_addr);
                        err_count++;
                    end
                end
                run_len++;
            end
            if (load_done) begin
                if (run_len != `CI_LOAD_CYCLES) begin
                    $display("ERR load %0d ram_en cycles: got %h expected %h",
                             load_idx, run_len, `CI_LOAD_CYCLES);
                    err_count++;
                end
                load_idx++;
                run_len = 0;
            end
            if (whole_done && !whole_seen) begin
                whole_seen = 1'b1;
                if (!prev_load_done || load_idx != TOTAL_LOADS) begin
                    $display("whole_done rose after load %0d, not right after the last load_done",
                             load_idx);
                    err_count++;
                end
            end
            if (whole_seen && !whole_done) begin
                $display("whole_done dropped at cycle %0d", cycle_count);
                err_count++;
            end
            prev_load_done = load_done;
        end
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with %0d loads done", cycle_count, load_idx);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        int errs_before;
        index_start    = 1'b0;
        check_en       = 1'b0;
        prev_load_done = 1'b0;
        whole_seen     = 1'b0;
        load_idx       = 0;
        run_len        = 0;
        err_count      = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        lfsr_state     = 32'ha9a4b939;
        @(negedge RST);
        @(negedge CLK);

        errs_before = err_count;
        if ({ram_en, load_done, whole_done} !== 3'b000) begin
            $display("ERR reset ram_en/load_done/whole_done: got %h expected %h",
                     {ram_en, load_done, whole_done}, 3'b000);
            err_count++;
        end
        if (ram_addr !== '0) begin
            $display("ERR reset ram_addr: got %h expected %h", ram_addr, 13'h0);
            err_count++;
        end
        report_test("reset", errs_before);
        check_en = 1'b1;

        // every fifth load also gets a start pulse while it runs
        for (int ch = 0; ch < `CI_CHANNELS; ch++) begin
            errs_before = err_count;
            for (int n = 0; n < CH_LOADS; n++) begin
                run_load((n % 5) == 2);
            end
            report_test($sformatf("channel_%0d_loads", ch), errs_before);
        end

        errs_before = err_count;
        if (whole_done !== 1'b1) begin
            $display("ERR whole_done: got %h expected %h", whole_done, 1'b1);
            err_count++;
        end
        if (load_idx != TOTAL_LOADS) begin
            $display("ERR load_done count: got %h expected %h", load_idx, TOTAL_LOADS);
            err_count++;
        end
        report_test("whole_done", errs_before);

        errs_before = err_count;
        repeat (3) begin
            pulse_start();
            repeat (`CI_LOAD_CYCLES + 2) @(negedge CLK);
        end
        if (whole_done !== 1'b1) begin
            $display("ERR whole_done after extra starts: got %h expected %h", whole_done, 1'b1);
            err_count++;
        end
        report_test("start_after_done", errs_before);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

// File: src.f
+incdir+src
src/index_pkg.sv
src/addr_pkg.sv
src/index_fsm.sv
src/window_counters.sv
src/filter_addr_gen.sv
src/image_addr_gen.sv
src/conv_indexer.sv
testbench/tb_clock_gen.sv
testbench/tb_conv_indexer.sv

// File: run.sh
#!/bin/sh
# compile and run the conv_indexer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_conv_indexer -f src.f
./obj_dir/Vtb_conv_indexer > sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
